//--- hw/converter_pkg.sv
// shared widths and sample types of the resonant converter control
// law coefficients and midscale level
// test waveform constants and the quarter-wave sine table
// pipeline alignment depths
package converter_pkg;

   // ==============================
   // sample widths and types
   // ==============================
   localparam int ADC_W = 14;

   // offset-binary word straight from the ADC
   typedef logic [ADC_W-1:0] adc_sample_t;
   // sample after midscale removal, one extra bit for the sign
   typedef logic signed [ADC_W:0] centered_t;
   typedef logic signed [31:0] product_t;

   // ==============================
   // switching law
   // ==============================
   localparam int MIDSCALE = 8191;
   // cos and sin of the switching angle, scaled by 1000
   localparam int C_THETA = -707;
   localparam int S_THETA = 707;

   // centring stage then product stage
   localparam int LAW_STAGES = 2;
   // input register plus the law, used to line up flags and enable
   localparam int ALIGN_STAGES = LAW_STAGES + 1;

   // ==============================
   // internal test waveform
   // ==============================
   localparam int WAVE_LEN = 200;
   localparam int QUARTER_LEN = 51;
   // quarter period, turns the sine into a cosine
   localparam int B_OFFSET = 50;
   localparam int SAMPLE_DIV = 10;

   typedef logic [7:0] phase_t;
   typedef logic [$clog2(QUARTER_LEN)-1:0] table_idx_t;
   typedef logic [$clog2(SAMPLE_DIV)-1:0] div_count_t;

   // round(8191 * sin(2*pi*k/200)) for the first quarter, k = 0 .. 50
   localparam adc_sample_t QUARTER_TABLE [QUARTER_LEN] = '{
      14'd0,    14'd257,  14'd514,  14'd771,  14'd1027, 14'd1281, 14'd1535, 14'd1787,
      14'd2037, 14'd2285, 14'd2531, 14'd2775, 14'd3015, 14'd3253, 14'd3488, 14'd3719,
      14'd3946, 14'd4170, 14'd4389, 14'd4604, 14'd4815, 14'd5020, 14'd5221, 14'd5417,
      14'd5607, 14'd5792, 14'd5971, 14'd6144, 14'd6311, 14'd6472, 14'd6627, 14'd6775,
      14'd6916, 14'd7050, 14'd7178, 14'd7298, 14'd7411, 14'd7517, 14'd7616, 14'd7707,
      14'd7790, 14'd7866, 14'd7934, 14'd7994, 14'd8046, 14'd8090, 14'd8126, 14'd8155,
      14'd8175, 14'd8187, 14'd8191
   };

endpackage

//--- hw/test_wave_source.sv
// internal quadrature test waveform
// sample strobe divider and phase counter
// quarter-wave table folded into a full sine and cosine
`timescale 1ns/1ps

module test_wave_source (
   input  logic                       OSC,
   input  logic                       i_rst,
   output converter_pkg::adc_sample_t o_wave_a,
   output converter_pkg::adc_sample_t o_wave_b
);

   converter_pkg::div_count_t div_cnt;
   logic                      sample_stb;
   converter_pkg::phase_t     phase_a;
   converter_pkg::phase_t     phase_b;

   // full-period sine from the quarter table, offset-binary around midscale
   function automatic converter_pkg::adc_sample_t fold_sine(input converter_pkg::phase_t p);
      converter_pkg::phase_t      half_p;
      converter_pkg::table_idx_t  idx;
      converter_pkg::adc_sample_t mag;
      logic                       lower;
      // second half period mirrors the first below midscale
      lower = (p >= converter_pkg::phase_t'(converter_pkg::WAVE_LEN / 2));
      if (lower) begin
         half_p = p - converter_pkg::phase_t'(converter_pkg::WAVE_LEN / 2);
      end else begin
         half_p = p;
      end
      // falling quarter reads the table backwards
      if (half_p >= converter_pkg::phase_t'(converter_pkg::QUARTER_LEN)) begin
         idx = converter_pkg::table_idx_t'(
            converter_pkg::phase_t'(converter_pkg::WAVE_LEN / 2) - half_p);
      end else begin
         idx = converter_pkg::table_idx_t'(half_p);
      end
      mag = converter_pkg::QUARTER_TABLE[idx];
      if (lower) begin
         return converter_pkg::adc_sample_t'(converter_pkg::MIDSCALE) - mag;
      end
      return converter_pkg::adc_sample_t'(converter_pkg::MIDSCALE) + mag;
   endfunction

   // ==============================
   // sample strobe
   // ==============================
   assign sample_stb = (div_cnt == converter_pkg::div_count_t'(converter_pkg::SAMPLE_DIV - 1));

   always_ff @(posedge OSC) begin
      if (i_rst) begin
         div_cnt <= '0;
      end else if (sample_stb) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   // ==============================
   // phase counters
   // ==============================
   always_ff @(posedge OSC) begin
      if (i_rst) begin
         phase_a <= '0;
      end else if (sample_stb) begin
         if (phase_a == converter_pkg::phase_t'(converter_pkg::WAVE_LEN - 1)) begin
            phase_a <= '0;
         end else begin
            phase_a <= phase_a + 1'b1;
         end
      end
   end

   // channel B leads by a quarter period, wrapped into one period
   always_comb begin
      if (phase_a >=
          converter_pkg::phase_t'(converter_pkg::WAVE_LEN - converter_pkg::B_OFFSET)) begin
         phase_b = phase_a -
                   converter_pkg::phase_t'(converter_pkg::WAVE_LEN - converter_pkg::B_OFFSET);
      end else begin
         phase_b = phase_a + converter_pkg::phase_t'(converter_pkg::B_OFFSET);
      end
   end

   // registered table outputs
   always_ff @(posedge OSC) begin
      o_wave_a <= fold_sine(phase_a);
      o_wave_b <= fold_sine(phase_b);
   end

endmodule

//--- hw/adc_front_end.sv
// ADC input registers and out-of-range flags
// selection between ADC samples and the internal test pair
`timescale 1ns/1ps

module adc_front_end (
   input  logic                       OSC,
   input  logic                       i_rst,
   input  converter_pkg::adc_sample_t i_adc_a,
   input  converter_pkg::adc_sample_t i_adc_b,
   input  logic                       i_adc_a_or,
   input  logic                       i_adc_b_or,
   input  logic                       i_use_adc,
   input  converter_pkg::adc_sample_t i_wave_a,
   input  converter_pkg::adc_sample_t i_wave_b,
   output converter_pkg::adc_sample_t o_sample_a,
   output converter_pkg::adc_sample_t o_sample_b,
   output logic                       o_a_or,
   output logic                       o_b_or
);

   converter_pkg::adc_sample_t adc_a_q;
   converter_pkg::adc_sample_t adc_b_q;
   logic                       use_adc_q;

   // flag delay lines, same depth as input register plus the law
   logic [converter_pkg::ALIGN_STAGES-1:0] a_or_pipe;
   logic [converter_pkg::ALIGN_STAGES-1:0] b_or_pipe;

   // ==============================
   // input registers
   // ==============================
   always_ff @(posedge OSC) begin
      adc_a_q <= i_adc_a;
      adc_b_q <= i_adc_b;
   end

   // mode is sampled with the data so a switch lands on a sample boundary
   always_ff @(posedge OSC) begin
      if (i_rst) begin
         use_adc_q <= 1'b0;
      end else begin
         use_adc_q <= i_use_adc;
      end
   end

   // ==============================
   // out-of-range flags
   // ==============================
   // flags mean nothing for the test waveform
   always_ff @(posedge OSC) begin
      if (i_rst) begin
         a_or_pipe <= '0;
         b_or_pipe <= '0;
      end else begin
         a_or_pipe <= {a_or_pipe[converter_pkg::ALIGN_STAGES-2:0], i_adc_a_or & i_use_adc};
         b_or_pipe <= {b_or_pipe[converter_pkg::ALIGN_STAGES-2:0], i_adc_b_or & i_use_adc};
      end
   end

   assign o_a_or = a_or_pipe[converter_pkg::ALIGN_STAGES-1];
   assign o_b_or = b_or_pipe[converter_pkg::ALIGN_STAGES-1];

   // sample select, test pair is already registered at its source
   assign o_sample_a = use_adc_q ? adc_a_q : i_wave_a;
   assign o_sample_b = use_adc_q ? adc_b_q : i_wave_b;

endmodule

//--- hw/switching_law.sv
// hybrid switching law, two pipeline stages
// stage one removes midscale from both samples
// stage two forms the coefficient product difference and takes its sign
`timescale 1ns/1ps

module switching_law (
   input  logic                       OSC,
   input  logic                       i_rst,
   input  converter_pkg::adc_sample_t i_sample_a,
   input  converter_pkg::adc_sample_t i_sample_b,
   output logic                       o_sigma,
   output logic                       o_sync
);

   converter_pkg::centered_t cent_a;
   converter_pkg::centered_t cent_b;
   converter_pkg::product_t  law_diff;

   // ==============================
   // stage one, centring
   // ==============================
   // offset binary to signed, range -8191 .. +8192
   always_ff @(posedge OSC) begin
      if (i_rst) begin
         cent_a <= '0;
         cent_b <= '0;
      end else begin
         cent_a <= converter_pkg::centered_t'({1'b0, i_sample_a}) -
                   converter_pkg::centered_t'(converter_pkg::MIDSCALE);
         cent_b <= converter_pkg::centered_t'({1'b0, i_sample_b}) -
                   converter_pkg::centered_t'(converter_pkg::MIDSCALE);
      end
   end

   // ==============================
   // stage two, law and decision
   // ==============================
   // worst case magnitude is about 1.2e7, far inside 32 bits
   always_comb begin
      law_diff = converter_pkg::product_t'(cent_a) *
                 converter_pkg::product_t'(converter_pkg::C_THETA) -
                 converter_pkg::product_t'(cent_b) *
                 converter_pkg::product_t'(converter_pkg::S_THETA);
   end

   // sigma set while the trajectory is on the negative side of the line
   always_ff @(posedge OSC) begin
      if (i_rst) begin
         o_sigma <= 1'b0;
         o_sync  <= 1'b0;
      end else begin
         o_sigma <= law_diff[$bits(converter_pkg::product_t)-1];
         // scope trigger, A below midscale
         o_sync  <= cent_a[converter_pkg::ADC_W];
      end
   end

endmodule

//--- hw/bridge_driver.sv
// complementary bridge gate drive from sigma
// converter on and out-of-range indicators
`timescale 1ns/1ps

module bridge_driver (
   input  logic OSC,
   input  logic i_rst,
   input  logic i_sigma,
   input  logic i_enable,
   input  logic i_a_or,
   input  logic i_b_or,
   output logic o_gate_hi,
   output logic o_gate_lo,
   output logic o_led_on,
   output logic o_led_a_or,
   output logic o_led_b_or
);

   // enable travels with the sample it was applied with
   logic [converter_pkg::ALIGN_STAGES-1:0] en_pipe;
   logic                                  en_aligned;

   assign en_aligned = en_pipe[converter_pkg::ALIGN_STAGES-1];

   always_ff @(posedge OSC) begin
      if (i_rst) begin
         en_pipe    <= '0;
         o_gate_hi  <= 1'b0;
         o_gate_lo  <= 1'b0;
         o_led_on   <= 1'b0;
         o_led_a_or <= 1'b0;
         o_led_b_or <= 1'b0;
      end else begin
         en_pipe    <= {en_pipe[converter_pkg::ALIGN_STAGES-2:0], i_enable};
         // both legs off when disabled, never both on
         o_gate_hi  <= i_sigma & en_aligned;
         o_gate_lo  <= ~i_sigma & en_aligned;
         o_led_on   <= en_aligned;
         o_led_a_or <= i_a_or & en_aligned;
         o_led_b_or <= i_b_or & en_aligned;
      end
   end

endmodule

//--- hw/resonant_control_top.sv
// resonant converter switching-law controller, top level
// test source, ADC front end, switching law and bridge driver
`timescale 1ns/1ps

module resonant_control_top (
   input  converter_pkg::adc_sample_t i_adc_a,
   input  converter_pkg::adc_sample_t i_adc_b,
   input  logic                       i_adc_a_or,
   input  logic                       i_adc_b_or,
   input  logic                       i_use_adc,
   input  logic                       i_enable,
   input  logic                       OSC,
   input  logic                       i_rst,
   output logic                       o_gate_hi,
   output logic                       o_gate_lo,
   output logic                       o_led_on,
   output logic                       o_led_a_or,
   output logic                       o_led_b_or,
   output logic                       o_sync
);

   converter_pkg::adc_sample_t wave_a;
   converter_pkg::adc_sample_t wave_b;
   converter_pkg::adc_sample_t sample_a;
   converter_pkg::adc_sample_t sample_b;
   logic                       a_or;
   logic                       b_or;
   logic                       sigma;

   test_wave_source test_wave_source_i (
      .OSC      (OSC),
      .i_rst    (i_rst),
      .o_wave_a (wave_a),
      .o_wave_b (wave_b)
   );

   // ==============================
   // sample path
   // ==============================
   adc_front_end adc_front_end_i (
      .OSC        (OSC),
      .i_rst      (i_rst),
      .i_adc_a    (i_adc_a),
      .i_adc_b    (i_adc_b),
      .i_adc_a_or (i_adc_a_or),
      .i_adc_b_or (i_adc_b_or),
      .i_use_adc  (i_use_adc),
      .i_wave_a   (wave_a),
      .i_wave_b   (wave_b),
      .o_sample_a (sample_a),
      .o_sample_b (sample_b),
      .o_a_or     (a_or),
      .o_b_or     (b_or)
   );

   switching_law switching_law_i (
      .OSC        (OSC),
      .i_rst      (i_rst),
      .i_sample_a (sample_a),
      .i_sample_b (sample_b),
      .o_sigma    (sigma),
      .o_sync     (o_sync)
   );

   // gate drive and indicators
   bridge_driver bridge_driver_i (
      .OSC        (OSC),
      .i_rst      (i_rst),
      .i_sigma    (sigma),
      .i_enable   (i_enable),
      .i_a_or     (a_or),
      .i_b_or     (b_or),
      .o_gate_hi  (o_gate_hi),
      .o_gate_lo  (o_gate_lo),
      .o_led_on   (o_led_on),
      .o_led_a_or (o_led_a_or),
      .o_led_b_or (o_led_b_or)
   );

endmodule

//--- bench/resonant_control_checker.sv
// concurrent assertions on the bridge gate outputs
// gate exclusion, reset state and enable gating
// bound into the controller top level
`timescale 1ns/1ps

module resonant_control_checker (
   input logic OSC,
   input logic i_rst,
   input logic i_enable,
   input logic o_gate_hi,
   input logic o_gate_lo,
   input logic o_led_on
);

   // complementary legs never conduct together
   gates_exclusive: assert property (@(posedge OSC) disable iff (i_rst)
      !(o_gate_hi && o_gate_lo))
      else $error("both bridge gates high in the same cycle");

   // everything off in the cycle after reset
   gates_off_after_reset: assert property (@(posedge OSC)
      i_rst |=> (!o_gate_hi && !o_gate_lo && !o_led_on))
      else $error("bridge gates or converter indicator not cleared by reset");

   // enable takes 4 cycles to reach the gates
   gates_follow_enable: assert property (@(posedge OSC) disable iff (i_rst)
      !$past(i_enable, 4) |-> (!o_gate_hi && !o_gate_lo))
      else $error("bridge gate active although enable was low 4 cycles earlier");

endmodule

bind resonant_control_top resonant_control_checker checker_i (
   .OSC       (OSC),
   .i_rst     (i_rst),
   .i_enable  (i_enable),
   .o_gate_hi (o_gate_hi),
   .o_gate_lo (o_gate_lo),
   .o_led_on  (o_led_on)
);

//--- bench/resonant_control_tb.sv
// testbench for the resonant converter switching-law controller
// clock, reset, vector file and random ADC stimulus
// 4-cycle expected-value pipeline and the test waveform period check
`timescale 1ns/1ps

module resonant_control_tb;

   localparam int MAX_VEC = 64;
   localparam int VEC_WORDS = 6;
   localparam int LATENCY = 4;
   localparam int WAVE_CYCLES = converter_pkg::WAVE_LEN * converter_pkg::SAMPLE_DIV;

   logic                       OSC;
   logic                       i_rst;
   converter_pkg::adc_sample_t i_adc_a;
   converter_pkg::adc_sample_t i_adc_b;
   logic                       i_adc_a_or;
   logic                       i_adc_b_or;
   logic                       i_use_adc;
   logic                       i_enable;
   logic                       o_gate_hi;
   logic                       o_gate_lo;
   logic                       o_led_on;
   logic                       o_led_a_or;
   logic                       o_led_b_or;
   logic                       o_sync;

   // mode, enable, A, B, flags, sigma
   logic [15:0] vec_mem [0:MAX_VEC*VEC_WORDS-1];
   // {valid, check gates, hi, lo, led on, led a, led b}, index 0 newest
   logic [6:0]  exp_pipe [0:LATENCY-1];
   // {check sync, A below midscale}, index 0 newest
   logic [1:0]  sync_pipe [0:LATENCY-1];
   int          error_count;
   int          check_count;
   int          vec_count;
   logic        timed_out;

   resonant_control_top dut_i (
      .i_adc_a    (i_adc_a),
      .i_adc_b    (i_adc_b),
      .i_adc_a_or (i_adc_a_or),
      .i_adc_b_or (i_adc_b_or),
      .i_use_adc  (i_use_adc),
      .i_enable   (i_enable),
      .OSC        (OSC),
      .i_rst      (i_rst),
      .o_gate_hi  (o_gate_hi),
      .o_gate_lo  (o_gate_lo),
      .o_led_on   (o_led_on),
      .o_led_a_or (o_led_a_or),
      .o_led_b_or (o_led_b_or),
      .o_sync     (o_sync)
   );

   always begin
      #4;
      OSC = ~OSC;
   end

   // sigma from the hybrid law on offset-binary samples
   function automatic logic law_sigma(input converter_pkg::adc_sample_t a,
                                      input converter_pkg::adc_sample_t b);
      longint diff;
      diff = (longint'(a) - longint'(converter_pkg::MIDSCALE)) * longint'(converter_pkg::C_THETA)
           - (longint'(b) - longint'(converter_pkg::MIDSCALE)) * longint'(converter_pkg::S_THETA);
      return (diff < 0);
   endfunction

   task automatic check_bit(input string what, input logic got, input logic exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic compare_outputs(input logic [6:0] e);
      if (e[6]) begin
         // gates only predictable in ADC mode or while disabled
         if (e[5]) begin
            check_bit("o_gate_hi", o_gate_hi, e[4]);
            check_bit("o_gate_lo", o_gate_lo, e[3]);
         end
         check_bit("o_led_on", o_led_on, e[2]);
         check_bit("o_led_a_or", o_led_a_or, e[1]);
         check_bit("o_led_b_or", o_led_b_or, e[0]);
      end
   endtask

   // one sample per falling edge, checks the one applied 4 edges ago
   task automatic apply_sample(input logic use_adc, input logic en,
                               input converter_pkg::adc_sample_t a,
                               input converter_pkg::adc_sample_t b,
                               input logic [1:0] flags, input logic sigma);
      int i;
      @(negedge OSC);
      compare_outputs(exp_pipe[LATENCY-1]);
      // sync leaves the law one stage ahead of the gates
      if (sync_pipe[LATENCY-2][1]) begin
         check_bit("o_sync", o_sync, sync_pipe[LATENCY-2][0]);
      end
      for (i = LATENCY - 1; i > 0; i--) begin
         exp_pipe[i]  = exp_pipe[i-1];
         sync_pipe[i] = sync_pipe[i-1];
      end
      exp_pipe[0] = {1'b1, use_adc | ~en, en & sigma, en & ~sigma, en,
                     en & use_adc & flags[1], en & use_adc & flags[0]};
      sync_pipe[0] = {use_adc, int'(a) < converter_pkg::MIDSCALE};
      i_use_adc  = use_adc;
      i_enable   = en;
      i_adc_a    = a;
      i_adc_b    = b;
      i_adc_a_or = flags[1];
      i_adc_b_or = flags[0];
   endtask

   task automatic check_reset_state();
      int n;
      for (n = 0; n < 6; n++) begin
         @(negedge OSC);
         check_bit("o_gate_hi after reset", o_gate_hi, 1'b0);
         check_bit("o_gate_lo after reset", o_gate_lo, 1'b0);
         check_bit("o_led_on after reset", o_led_on, 1'b0);
         check_bit("o_led_a_or after reset", o_led_a_or, 1'b0);
         check_bit("o_led_b_or after reset", o_led_b_or, 1'b0);
         check_bit("o_sync after reset", o_sync, 1'b0);
      end
   endtask

   // ==============================
   // test waveform period
   // ==============================
   task automatic measure_wave_period(output logic timeout);
      int   cycle;
      int   hi_rises;
      int   sync_rises;
      int   hi_last;
      int   sync_last;
      int   hi_period;
      int   sync_period;
      logic hi_prev;
      logic sync_prev;
      @(negedge OSC);
      i_use_adc  = 1'b0;
      i_enable   = 1'b1;
      i_adc_a_or = 1'b1;
      i_adc_b_or = 1'b1;
      hi_prev    = o_gate_hi;
      sync_prev  = o_sync;
      hi_rises   = 0;
      sync_rises = 0;
      hi_last    = 0;
      sync_last  = 0;
      hi_period  = 0;
      sync_period = 0;
      cycle      = 0;
      timeout    = 1'b0;
      // first rise may come from the mode switch, so time the 2nd to 3rd
      while ((hi_rises < 3 || sync_rises < 3) && !timeout) begin
         @(negedge OSC);
         cycle++;
         if (o_gate_hi && !hi_prev) begin
            hi_rises++;
            if (hi_rises == 3) begin
               hi_period = cycle - hi_last;
            end
            hi_last = cycle;
         end
         if (o_sync && !sync_prev) begin
            sync_rises++;
            if (sync_rises == 3) begin
               sync_period = cycle - sync_last;
            end
            sync_last = cycle;
         end
         if (cycle >= LATENCY) begin
            check_bit("o_led_on in test mode", o_led_on, 1'b1);
            check_bit("o_led_a_or in test mode", o_led_a_or, 1'b0);
            check_bit("o_led_b_or in test mode", o_led_b_or, 1'b0);
         end
         hi_prev   = o_gate_hi;
         sync_prev = o_sync;
         if (cycle >= 4 * WAVE_CYCLES) begin
            timeout = 1'b1;
         end
      end
      if (timeout) begin
         $display("timeout: no three rising edges on o_gate_hi and o_sync within %0d cycles",
                  4 * WAVE_CYCLES);
      end else begin
         check_count += 2;
         if (hi_period != WAVE_CYCLES) begin
            error_count++;
            $display("error at %0t: o_gate_hi period is %0d cycles, expected %0d",
                     $time, hi_period, WAVE_CYCLES);
         end
         if (sync_period != WAVE_CYCLES) begin
            error_count++;
            $display("error at %0t: o_sync period is %0d cycles, expected %0d",
                     $time, sync_period, WAVE_CYCLES);
         end
      end
   endtask

   // ==============================
   // main sequence
   // ==============================
   initial begin
      int                         j;
      int                         base;
      converter_pkg::adc_sample_t va;
      converter_pkg::adc_sample_t vb;
      logic                       vsig;
      logic [1:0]                 rflags;
      OSC        = 1'b0;
      i_rst      = 1'b1;
      i_adc_a    = '0;
      i_adc_b    = '0;
      i_adc_a_or = 1'b0;
      i_adc_b_or = 1'b0;
      i_use_adc  = 1'b0;
      i_enable   = 1'b0;
      error_count = 0;
      check_count = 0;
      timed_out   = 1'b0;
      void'($urandom(395));
      for (j = 0; j < LATENCY; j++) begin
         exp_pipe[j]  = '0;
         sync_pipe[j] = '0;
      end
      // unused entries mark the end of the vector list
      for (j = 0; j < MAX_VEC * VEC_WORDS; j++) begin
         vec_mem[j] = 16'hffff;
      end
      $readmemh("bench/resonant_control_tests.txt", vec_mem);

      for (j = 0; j < 4; j++) begin
         @(posedge OSC);
      end
      @(negedge OSC);
      i_rst = 1'b0;
      check_reset_state();

      vec_count = 0;
      while (vec_count < MAX_VEC && vec_mem[vec_count * VEC_WORDS] != 16'hffff) begin
         base = vec_count * VEC_WORDS;
         va   = vec_mem[base+2][converter_pkg::ADC_W-1:0];
         vb   = vec_mem[base+3][converter_pkg::ADC_W-1:0];
         vsig = vec_mem[base+5][0];
         check_count++;
         if (law_sigma(va, vb) !== vsig) begin
            error_count++;
            $display("error at %0t: vector %0d sigma column disagrees with the law",
                     $time, vec_count);
         end
         apply_sample(vec_mem[base][0], vec_mem[base+1][0], va, vb,
                      vec_mem[base+4][1:0], vsig);
         // random ADC pair between file vectors
         va     = converter_pkg::adc_sample_t'($urandom);
         vb     = converter_pkg::adc_sample_t'($urandom);
         rflags = 2'($urandom);
         apply_sample(1'b1, 1'b1, va, vb, rflags, law_sigma(va, vb));
         vec_count++;
      end
      if (vec_count == 0) begin
         error_count++;
         $display("no test vectors were read from bench/resonant_control_tests.txt");
      end
      // flush the last samples through the pipeline
      for (j = 0; j < LATENCY; j++) begin
         apply_sample(1'b1, 1'b0, '0, '0, 2'b00, 1'b0);
      end

      measure_wave_period(timed_out);

      $display("vectors %0d, checks %0d, errors %0d, timeouts %0d",
               vec_count, check_count, error_count, timed_out);
      if (error_count == 0 && !timed_out) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- bench/resonant_control_tests.txt
// columns: mode (1 ADC, 0 test wave), enable, channel A, channel B (hex, offset binary),
// OR flags (bit 1 A, bit 0 B), expected sigma (1 when A + B is above 2 * midscale)
1 1 1fff 1fff 0 0
1 1 2000 1fff 0 1
1 1 1fff 2000 0 1
1 1 1ffe 2000 0 0
1 1 3fff 3fff 0 1
1 1 0000 0000 0 0
1 1 3fff 0000 0 1
1 1 0000 3fff 1 1
1 1 3000 1000 2 1
1 1 1000 3000 1 1
1 1 0fff 2fff 3 0
1 1 2abc 1544 0 1
1 1 1234 2dca 0 0
// converter disabled
1 0 3fff 3fff 3 1
1 0 0000 0000 0 0
1 0 2500 2500 2 1
1 1 0100 0200 0 0
1 1 3e00 3f00 1 1
// test waveform selected, flags must read 0
0 1 3fff 3fff 3 1
0 0 0000 0000 3 0
1 1 1fff 0001 2 0
1 1 0001 3ffe 0 1
1 1 2000 2000 0 1
1 1 1fff 1ffe 0 0
1 1 1555 2aaa 3 1
1 1 2aaa 1554 0 0

//--- resonant_control.f
hw/converter_pkg.sv
hw/test_wave_source.sv
hw/adc_front_end.sv
hw/switching_law.sv
hw/bridge_driver.sv
hw/resonant_control_top.sv
bench/resonant_control_checker.sv
bench/resonant_control_tb.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the resonant controller testbench
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module resonant_control_tb \
   -f resonant_control.f -Mdir obj_dir > build.log 2>&1 &&
   ./obj_dir/Vresonant_control_tb > sim.log 2>&1
grep -qx "Testbench passed" sim.log && echo "simulation passed" && exit 0 || {
   echo "simulation failed, see build.log and sim.log"
   exit 1
}
